//--- design/ctrlPkg.sv
package ctrlPkg;

	// instruction field widths
	localparam int opW = 6;
	localparam int regW = 5;
	localparam int functW = 6;
	localparam int immW = 16;
	localparam int excW = 5;

	// select and control widths
	localparam int aluOpW = 5;
	localparam int mdOpW = 4;
	localparam int extW = 2;
	localparam int npcW = 2;
	localparam int brKindW = 3;
	localparam int jmpKindW = 2;
	localparam int movKindW = 2;
	localparam int wbSelW = 3;
	localparam int dmSelW = 4;
	localparam int regDstW = 2;
	localparam int hiloSelW = 2;

	// one instruction word, seen as R-format or I-format
	typedef union packed {
		struct packed {
			logic [opW-1:0] op;
			logic [regW-1:0] rs;
			logic [regW-1:0] rt;
			logic [regW-1:0] rd;
			logic [regW-1:0] shamt;
			logic [functW-1:0] funct;
		} rFmt;
		struct packed {
			logic [opW-1:0] op;
			logic [regW-1:0] rs;
			logic [regW-1:0] rt;
			logic [immW-1:0] imm;
		} iFmt;
	} instrWord_u;

	// primary opcodes
	localparam logic [opW-1:0] opSpecial = 6'b000000;
	localparam logic [opW-1:0] opRegimm = 6'b000001;
	localparam logic [opW-1:0] opJ = 6'b000010;
	localparam logic [opW-1:0] opJal = 6'b000011;
	localparam logic [opW-1:0] opBeq = 6'b000100;
	localparam logic [opW-1:0] opBne = 6'b000101;
	localparam logic [opW-1:0] opBlez = 6'b000110;
	localparam logic [opW-1:0] opBgtz = 6'b000111;
	localparam logic [opW-1:0] opAddi = 6'b001000;
	localparam logic [opW-1:0] opAddiu = 6'b001001;
	localparam logic [opW-1:0] opSlti = 6'b001010;
	localparam logic [opW-1:0] opSltiu = 6'b001011;
	localparam logic [opW-1:0] opAndi = 6'b001100;
	localparam logic [opW-1:0] opOri = 6'b001101;
	localparam logic [opW-1:0] opXori = 6'b001110;
	localparam logic [opW-1:0] opLui = 6'b001111;
	localparam logic [opW-1:0] opCop0 = 6'b010000;
	localparam logic [opW-1:0] opLb = 6'b100000;
	localparam logic [opW-1:0] opLh = 6'b100001;
	localparam logic [opW-1:0] opLwl = 6'b100010;
	localparam logic [opW-1:0] opLw = 6'b100011;
	localparam logic [opW-1:0] opLbu = 6'b100100;
	localparam logic [opW-1:0] opLhu = 6'b100101;
	localparam logic [opW-1:0] opLwr = 6'b100110;
	localparam logic [opW-1:0] opSb = 6'b101000;
	localparam logic [opW-1:0] opSh = 6'b101001;
	localparam logic [opW-1:0] opSwl = 6'b101010;
	localparam logic [opW-1:0] opSw = 6'b101011;
	localparam logic [opW-1:0] opSwr = 6'b101110;

	// SPECIAL funct field, ERET shares the field under COP0
	localparam logic [functW-1:0] fnSll = 6'b000000;
	localparam logic [functW-1:0] fnSrl = 6'b000010;
	localparam logic [functW-1:0] fnSra = 6'b000011;
	localparam logic [functW-1:0] fnSllv = 6'b000100;
	localparam logic [functW-1:0] fnSrlv = 6'b000110;
	localparam logic [functW-1:0] fnSrav = 6'b000111;
	localparam logic [functW-1:0] fnJr = 6'b001000;
	localparam logic [functW-1:0] fnJalr = 6'b001001;
	localparam logic [functW-1:0] fnMovz = 6'b001010;
	localparam logic [functW-1:0] fnMovn = 6'b001011;
	localparam logic [functW-1:0] fnSyscall = 6'b001100;
	localparam logic [functW-1:0] fnBreak = 6'b001101;
	localparam logic [functW-1:0] fnSync = 6'b001111;
	localparam logic [functW-1:0] fnMfhi = 6'b010000;
	localparam logic [functW-1:0] fnMthi = 6'b010001;
	localparam logic [functW-1:0] fnMflo = 6'b010010;
	localparam logic [functW-1:0] fnMtlo = 6'b010011;
	localparam logic [functW-1:0] fnMult = 6'b011000;
	localparam logic [functW-1:0] fnMultu = 6'b011001;
	localparam logic [functW-1:0] fnDiv = 6'b011010;
	localparam logic [functW-1:0] fnDivu = 6'b011011;
	localparam logic [functW-1:0] fnAdd = 6'b100000;
	localparam logic [functW-1:0] fnAddu = 6'b100001;
	localparam logic [functW-1:0] fnSub = 6'b100010;
	localparam logic [functW-1:0] fnSubu = 6'b100011;
	localparam logic [functW-1:0] fnAnd = 6'b100100;
	localparam logic [functW-1:0] fnOr = 6'b100101;
	localparam logic [functW-1:0] fnXor = 6'b100110;
	localparam logic [functW-1:0] fnNor = 6'b100111;
	localparam logic [functW-1:0] fnSlt = 6'b101010;
	localparam logic [functW-1:0] fnSltu = 6'b101011;
	localparam logic [functW-1:0] fnEret = 6'b011000;

	// REGIMM rt and COP0 rs sub-opcodes
	localparam logic [regW-1:0] rtBltz = 5'b00000;
	localparam logic [regW-1:0] rtBgez = 5'b00001;
	localparam logic [regW-1:0] rtBltzal = 5'b10000;
	localparam logic [regW-1:0] rtBgezal = 5'b10001;
	localparam logic [regW-1:0] rsMfc0 = 5'b00000;
	localparam logic [regW-1:0] rsMtc0 = 5'b00100;

	// ALU operations
	localparam logic [aluOpW-1:0] aluAdd = 5'd0;
	localparam logic [aluOpW-1:0] aluSub = 5'd1;
	localparam logic [aluOpW-1:0] aluOr = 5'd2;
	localparam logic [aluOpW-1:0] aluAnd = 5'd3;
	localparam logic [aluOpW-1:0] aluNor = 5'd4;
	localparam logic [aluOpW-1:0] aluXor = 5'd5;
	localparam logic [aluOpW-1:0] aluSll = 5'd6;
	localparam logic [aluOpW-1:0] aluSrl = 5'd7;
	localparam logic [aluOpW-1:0] aluSra = 5'd8;
	localparam logic [aluOpW-1:0] aluSlt = 5'd9;
	localparam logic [aluOpW-1:0] aluSltu = 5'd10;
	localparam logic [aluOpW-1:0] aluMove = 5'd11;
	localparam logic [aluOpW-1:0] aluAddu = 5'd12;
	localparam logic [aluOpW-1:0] aluSubu = 5'd16;
	localparam logic [aluOpW-1:0] aluNone = 5'd31;

	// multiply/divide unit
	localparam logic [mdOpW-1:0] mdMultu = 4'd0;
	localparam logic [mdOpW-1:0] mdMult = 4'd1;
	localparam logic [mdOpW-1:0] mdDivu = 4'd2;
	localparam logic [mdOpW-1:0] mdDiv = 4'd3;

	localparam logic [extW-1:0] extZero = 2'd0;
	localparam logic [extW-1:0] extSign = 2'd1;
	localparam logic [extW-1:0] extUpper = 2'd2;

	localparam logic [npcW-1:0] npcSeq = 2'd0;
	localparam logic [npcW-1:0] npcBranch = 2'd1;
	localparam logic [npcW-1:0] npcJump = 2'd2;
	localparam logic [npcW-1:0] npcJumpReg = 2'd3;

	localparam logic [brKindW-1:0] brEq = 3'd0;
	localparam logic [brKindW-1:0] brNe = 3'd1;
	localparam logic [brKindW-1:0] brGez = 3'd2;
	localparam logic [brKindW-1:0] brLtz = 3'd3;
	localparam logic [brKindW-1:0] brLez = 3'd4;
	localparam logic [brKindW-1:0] brGtz = 3'd5;
	localparam logic [brKindW-1:0] brNone = 3'd7;

	localparam logic [jmpKindW-1:0] jmpNone = 2'd0;
	localparam logic [jmpKindW-1:0] jmpDirect = 2'd1;
	localparam logic [jmpKindW-1:0] jmpRegister = 2'd2;

	localparam logic [movKindW-1:0] movNone = 2'd0;
	localparam logic [movKindW-1:0] movZ = 2'd1;
	localparam logic [movKindW-1:0] movN = 2'd2;

	// write-back source
	localparam logic [wbSelW-1:0] wbHilo = 3'd0;
	localparam logic [wbSelW-1:0] wbImm = 3'd1;
	localparam logic [wbSelW-1:0] wbAlu = 3'd2;
	localparam logic [wbSelW-1:0] wbLink = 3'd3;
	localparam logic [wbSelW-1:0] wbMem = 3'd4;
	localparam logic [wbSelW-1:0] wbCp0 = 3'd5;

	// data memory access size and direction
	localparam logic [dmSelW-1:0] dmSb = 4'd0;
	localparam logic [dmSelW-1:0] dmSh = 4'd1;
	localparam logic [dmSelW-1:0] dmSw = 4'd2;
	localparam logic [dmSelW-1:0] dmSwl = 4'd3;
	localparam logic [dmSelW-1:0] dmSwr = 4'd4;
	localparam logic [dmSelW-1:0] dmLbu = 4'd5;
	localparam logic [dmSelW-1:0] dmLb = 4'd6;
	localparam logic [dmSelW-1:0] dmLhu = 4'd7;
	localparam logic [dmSelW-1:0] dmLh = 4'd8;
	localparam logic [dmSelW-1:0] dmLwl = 4'd9;
	localparam logic [dmSelW-1:0] dmLwr = 4'd10;
	localparam logic [dmSelW-1:0] dmLw = 4'd11;

	localparam logic [regDstW-1:0] dstRt = 2'd0;
	localparam logic [regDstW-1:0] dstRd = 2'd1;
	localparam logic [regDstW-1:0] dstR31 = 2'd2;

	localparam logic [hiloSelW-1:0] hiloSelLo = 2'd0;
	localparam logic [hiloSelW-1:0] hiloSelHi = 2'd1;
	localparam logic [hiloSelW-1:0] hiloSelMd = 2'd2;

	// exception codes
	localparam logic [excW-1:0] excRi = 5'd10;
	localparam logic [excW-1:0] excBp = 5'd9;
	localparam logic [excW-1:0] excSys = 5'd8;

endpackage

//--- design/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder (
	input ctrlPkg::instrWord_u instr,
	output logic regWr,
	output logic [ctrlPkg::regDstW-1:0] regDstSel,
	output logic [ctrlPkg::wbSelW-1:0] wbSel,
	output logic [ctrlPkg::aluOpW-1:0] aluOp,
	output logic aluShamtSrc,
	output logic [ctrlPkg::extW-1:0] extOp,
	output logic dmWr,
	output logic dmRd,
	output logic [ctrlPkg::dmSelW-1:0] dmSel,
	output logic hiloWr,
	output logic [ctrlPkg::hiloSelW-1:0] hiloWrSel,
	output logic hiloRdHi,
	output logic mdStart,
	output logic [ctrlPkg::mdOpW-1:0] mdOp,
	output logic aluSrcImm,
	output logic isBranch,
	output logic [ctrlPkg::brKindW-1:0] brKind,
	output logic [ctrlPkg::jmpKindW-1:0] jmpKind,
	output logic [ctrlPkg::movKindW-1:0] movKind,
	output logic eretFlush,
	output logic cp0Wr,
	output logic cp0Rd,
	output logic recognized,
	output logic breakOp,
	output logic syscallOp
);
	import ctrlPkg::*;

	logic [opW-1:0] op;
	logic [regW-1:0] rs;
	logic [regW-1:0] rt;
	logic [functW-1:0] funct;
	logic syncOp;
	logic cop0Op;

	// op is common to both views
	assign op = instr.iFmt.op;
	assign rt = instr.iFmt.rt;
	assign rs = instr.rFmt.rs;
	assign funct = instr.rFmt.funct;

	always_comb begin
		regWr = 1'b0;
		regDstSel = dstRt;
		wbSel = wbAlu;
		aluOp = aluNone;
		aluShamtSrc = 1'b0;
		extOp = extZero;
		dmWr = 1'b0;
		dmRd = 1'b0;
		hiloWr = 1'b0;
		hiloWrSel = hiloSelLo;
		hiloRdHi = 1'b0;
		mdStart = 1'b0;
		mdOp = mdMultu;
		aluSrcImm = 1'b1;
		isBranch = 1'b0;
		brKind = brNone;
		jmpKind = jmpNone;
		movKind = movNone;
		eretFlush = 1'b0;
		cp0Wr = 1'b0;
		cp0Rd = 1'b0;
		breakOp = 1'b0;
		syscallOp = 1'b0;
		syncOp = 1'b0;
		cop0Op = 1'b0;
		case (op)
			opSpecial: begin
				regDstSel = dstRd;
				aluSrcImm = 1'b0;
				case (funct)
					fnAdd: aluOp = aluAdd;
					fnAddu: aluOp = aluAddu;
					fnSub: aluOp = aluSub;
					fnSubu: aluOp = aluSubu;
					fnAnd: aluOp = aluAnd;
					fnOr: aluOp = aluOr;
					fnXor: aluOp = aluXor;
					fnNor: aluOp = aluNor;
					fnSlt: aluOp = aluSlt;
					fnSltu: aluOp = aluSltu;
					fnSll, fnSllv: aluOp = aluSll;
					fnSrl, fnSrlv: aluOp = aluSrl;
					fnSra, fnSrav: aluOp = aluSra;
					fnMovz, fnMovn: aluOp = aluMove;
					default: aluOp = aluNone;
				endcase
				// every funct with an ALU op writes rd
				if (aluOp != aluNone)
					regWr = 1'b1;
				case (funct)
					fnSll, fnSrl, fnSra: aluShamtSrc = 1'b1;
					fnJr: begin
						isBranch = 1'b1;
						jmpKind = jmpRegister;
					end
					fnJalr: begin
						isBranch = 1'b1;
						jmpKind = jmpRegister;
						regWr = 1'b1;
						wbSel = wbLink;
					end
					fnMfhi, fnMflo: begin
						regWr = 1'b1;
						wbSel = wbHilo;
						hiloRdHi = (funct == fnMfhi);
					end
					fnMthi: begin
						hiloWr = 1'b1;
						hiloWrSel = hiloSelHi;
					end
					fnMtlo: hiloWr = 1'b1;
					fnMult, fnMultu, fnDiv, fnDivu: begin
						hiloWr = 1'b1;
						hiloWrSel = hiloSelMd;
						mdStart = 1'b1;
						wbSel = wbHilo;
						case (funct)
							fnMult: mdOp = mdMult;
							fnDivu: mdOp = mdDivu;
							fnDiv: mdOp = mdDiv;
							default: mdOp = mdMultu;
						endcase
					end
					fnMovz: movKind = movZ;
					fnMovn: movKind = movN;
					fnSyscall: syscallOp = 1'b1;
					fnBreak: breakOp = 1'b1;
					fnSync: syncOp = 1'b1;
					default: ;
				endcase
			end
			opAddi, opAddiu, opSlti, opSltiu: begin
				regWr = 1'b1;
				extOp = extSign;
				case (op)
					opAddi: aluOp = aluAdd;
					opAddiu: aluOp = aluAddu;
					opSlti: aluOp = aluSlt;
					default: aluOp = aluSltu;
				endcase
			end
			opAndi, opOri, opXori: begin
				regWr = 1'b1;
				case (op)
					opAndi: aluOp = aluAnd;
					opOri: aluOp = aluOr;
					default: aluOp = aluXor;
				endcase
			end
			opLui: begin
				regWr = 1'b1;
				extOp = extUpper;
				wbSel = wbImm;
			end
			// address is base plus sign-extended offset
			opLb, opLh, opLwl, opLw, opLbu, opLhu, opLwr: begin
				regWr = 1'b1;
				dmRd = 1'b1;
				aluOp = aluAdd;
				extOp = extSign;
				wbSel = wbMem;
			end
			opSb, opSh, opSwl, opSw, opSwr: begin
				dmWr = 1'b1;
				aluOp = aluAdd;
				extOp = extSign;
			end
			opBeq, opBne, opBlez, opBgtz: begin
				isBranch = 1'b1;
				case (op)
					opBeq: brKind = brEq;
					opBne: brKind = brNe;
					opBlez: brKind = brLez;
					default: brKind = brGtz;
				endcase
			end
			opRegimm: begin
				regDstSel = dstR31;
				wbSel = wbLink;
				case (rt)
					rtBltz: brKind = brLtz;
					rtBgez: brKind = brGez;
					rtBltzal: brKind = brLtz;
					rtBgezal: brKind = brGez;
					default: brKind = brNone;
				endcase
				isBranch = (brKind != brNone);
				// the link forms have rt[4] set
				regWr = isBranch && rt[4];
			end
			opJ: begin
				isBranch = 1'b1;
				jmpKind = jmpDirect;
			end
			opJal: begin
				isBranch = 1'b1;
				jmpKind = jmpDirect;
				regWr = 1'b1;
				regDstSel = dstR31;
				wbSel = wbLink;
			end
			opCop0: begin
				cop0Op = 1'b1;
				eretFlush = (funct == fnEret);
				cp0Wr = (rs == rsMtc0);
				cp0Rd = (rs == rsMfc0);
				if (rs == rsMfc0) begin
					regWr = 1'b1;
					wbSel = wbCp0;
				end
			end
			default: ;
		endcase
	end

	// access size, LW when nothing else matches
	always_comb begin
		case (op)
			opSb: dmSel = dmSb;
			opSh: dmSel = dmSh;
			opSw: dmSel = dmSw;
			opSwl: dmSel = dmSwl;
			opSwr: dmSel = dmSwr;
			opLbu: dmSel = dmLbu;
			opLb: dmSel = dmLb;
			opLhu: dmSel = dmLhu;
			opLh: dmSel = dmLh;
			opLwl: dmSel = dmLwl;
			opLwr: dmSel = dmLwr;
			default: dmSel = dmLw;
		endcase
	end

	// anything with a visible effect counts as a known instruction
	assign recognized = regWr || hiloWr || dmWr || breakOp || syscallOp || syncOp ||
		cop0Op || isBranch;

endmodule

//--- design/condResolver.sv
`timescale 1ns/1ns

module condResolver (
	input logic [ctrlPkg::brKindW-1:0] brKind,
	input logic [ctrlPkg::jmpKindW-1:0] jmpKind,
	input logic [ctrlPkg::movKindW-1:0] movKind,
	input logic cmpEq,
	input logic [1:0] cmpSign,
	input logic cmpRtZero,
	output logic [ctrlPkg::npcW-1:0] npcOp,
	output logic movEnable
);
	import ctrlPkg::*;

	logic taken;

	// cmpSign: 01 positive, 10 negative, 00 zero
	always_comb begin
		case (brKind)
			brEq: taken = cmpEq;
			brNe: taken = !cmpEq;
			brGez: taken = (cmpSign != 2'b10);
			brLtz: taken = (cmpSign == 2'b10);
			brLez: taken = (cmpSign != 2'b01);
			brGtz: taken = (cmpSign == 2'b01);
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		if (brKind != brNone) begin
			npcOp = taken ? npcBranch : npcSeq;
		end else begin
			case (jmpKind)
				jmpDirect: npcOp = npcJump;
				jmpRegister: npcOp = npcJumpReg;
				default: npcOp = npcSeq;
			endcase
		end
	end

	// the move is cancelled when its rt test fails
	assign movEnable = !((movKind == movZ && !cmpRtZero) ||
		(movKind == movN && cmpRtZero));

endmodule

//--- design/excDetect.sv
`timescale 1ns/1ns

module excDetect (
	input logic clk,
	input logic rst,
	input logic recognized,
	input logic breakOp,
	input logic syscallOp,
	input logic fetchExc,
	input logic [ctrlPkg::excW-1:0] fetchExcCode,
	input logic ifFlush,
	output logic idException,
	output logic [ctrlPkg::excW-1:0] idExcCode
);
	import ctrlPkg::*;

	logic postReset;

	// high through reset and for one cycle after release
	always_ff @(posedge clk) begin
		if (!rst)
			postReset <= 1'b1;
		else
			postReset <= 1'b0;
	end

	// fetch side exception is older and wins
	always_comb begin
		idException = 1'b1;
		if (fetchExc)
			idExcCode = fetchExcCode;
		else if (!recognized && !postReset && !ifFlush)
			idExcCode = excRi;
		else if (breakOp)
			idExcCode = excBp;
		else if (syscallOp)
			idExcCode = excSys;
		else begin
			idException = 1'b0;
			idExcCode = '0;
		end
	end

endmodule

//--- design/decodeCtrl.sv
`timescale 1ns/1ns

module decodeCtrl (
	input logic clk,
	input logic rst,
	input ctrlPkg::instrWord_u instr,
	input logic cmpEq,
	input logic [1:0] cmpSign,
	input logic cmpRtZero,
	input logic fetchExc,
	input logic [ctrlPkg::excW-1:0] fetchExcCode,
	input logic ifFlush,
	output logic regWr,
	output logic [ctrlPkg::regDstW-1:0] regDstSel,
	output logic [ctrlPkg::wbSelW-1:0] wbSel,
	output logic [ctrlPkg::aluOpW-1:0] aluOp,
	output logic aluShamtSrc,
	output logic [ctrlPkg::extW-1:0] extOp,
	output logic dmWr,
	output logic dmRd,
	output logic [ctrlPkg::dmSelW-1:0] dmSel,
	output logic hiloWr,
	output logic [ctrlPkg::hiloSelW-1:0] hiloWrSel,
	output logic hiloRdHi,
	output logic mdStart,
	output logic [ctrlPkg::mdOpW-1:0] mdOp,
	output logic aluSrcImm,
	output logic isBranch,
	output logic eretFlush,
	output logic cp0Wr,
	output logic cp0Rd,
	output logic [ctrlPkg::npcW-1:0] npcOp,
	output logic movEnable,
	output logic idException,
	output logic [ctrlPkg::excW-1:0] idExcCode
);
	import ctrlPkg::*;

	logic [brKindW-1:0] brKind;
	logic [jmpKindW-1:0] jmpKind;
	logic [movKindW-1:0] movKind;
	logic recognized;
	logic breakOp;
	logic syscallOp;

	instrDecoder dec0 (
		.instr(instr),
		.regWr(regWr),
		.regDstSel(regDstSel),
		.wbSel(wbSel),
		.aluOp(aluOp),
		.aluShamtSrc(aluShamtSrc),
		.extOp(extOp),
		.dmWr(dmWr),
		.dmRd(dmRd),
		.dmSel(dmSel),
		.hiloWr(hiloWr),
		.hiloWrSel(hiloWrSel),
		.hiloRdHi(hiloRdHi),
		.mdStart(mdStart),
		.mdOp(mdOp),
		.aluSrcImm(aluSrcImm),
		.isBranch(isBranch),
		.brKind(brKind),
		.jmpKind(jmpKind),
		.movKind(movKind),
		.eretFlush(eretFlush),
		.cp0Wr(cp0Wr),
		.cp0Rd(cp0Rd),
		.recognized(recognized),
		.breakOp(breakOp),
		.syscallOp(syscallOp)
	);

	// next-PC and conditional move from comparator flags
	condResolver cond0 (
		.brKind(brKind),
		.jmpKind(jmpKind),
		.movKind(movKind),
		.cmpEq(cmpEq),
		.cmpSign(cmpSign),
		.cmpRtZero(cmpRtZero),
		.npcOp(npcOp),
		.movEnable(movEnable)
	);

	excDetect exc0 (
		.clk(clk),
		.rst(rst),
		.recognized(recognized),
		.breakOp(breakOp),
		.syscallOp(syscallOp),
		.fetchExc(fetchExc),
		.fetchExcCode(fetchExcCode),
		.ifFlush(ifFlush),
		.idException(idException),
		.idExcCode(idExcCode)
	);

endmodule

//--- include/ctrlRefModel.svh
`ifndef CTRL_REF_MODEL_SVH
`define CTRL_REF_MODEL_SVH

// expected value of every checked DUT output for one vector
typedef struct packed {
	logic regWr;
	logic [regDstW-1:0] regDstSel;
	logic [wbSelW-1:0] wbSel;
	logic [aluOpW-1:0] aluOp;
	logic aluShamtSrc;
	logic [extW-1:0] extOp;
	logic aluSrcImm;
	logic dmWr;
	logic dmRd;
	logic [dmSelW-1:0] dmSel;
	logic hiloWr;
	logic [hiloSelW-1:0] hiloWrSel;
	logic hiloRdHi;
	logic mdStart;
	logic [mdOpW-1:0] mdOp;
	logic isBranch;
	logic eretFlush;
	logic cp0Wr;
	logic cp0Rd;
	logic [npcW-1:0] npcOp;
	logic movEnable;
	logic idException;
	logic [excW-1:0] idExcCode;
} expectOut_t;

function automatic expectOut_t predictOutputs(
	input instrWord_u iw,
	input logic eq,
	input logic [1:0] sign,
	input logic rtZero,
	input logic fExc,
	input logic [excW-1:0] fCode,
	input logic flush,
	input logic resetWin
);
	expectOut_t e;
	logic [opW-1:0] op;
	logic [functW-1:0] fn;
	logic [regW-1:0] rt;
	logic known;
	logic brk;
	logic sys;
	logic cond;
	logic taken;
	logic memLoad;
	logic memStore;

	op = iw.iFmt.op;
	rt = iw.iFmt.rt;
	fn = iw.rFmt.funct;
	e = '0;
	e.wbSel = wbAlu;
	e.aluOp = aluNone;
	e.aluSrcImm = (op != opSpecial);
	e.dmSel = dmLw;
	e.movEnable = 1'b1;
	known = 1'b1;
	brk = 1'b0;
	sys = 1'b0;
	cond = 1'b0;
	taken = 1'b0;
	memLoad = 1'b0;
	memStore = 1'b0;
	case (op)
		opSpecial: begin
			// R-type writes rd unless cleared below
			e.regDstSel = dstRd;
			e.regWr = 1'b1;
			case (fn)
				fnAdd: e.aluOp = aluAdd;
				fnAddu: e.aluOp = aluAddu;
				fnSub: e.aluOp = aluSub;
				fnSubu: e.aluOp = aluSubu;
				fnAnd: e.aluOp = aluAnd;
				fnOr: e.aluOp = aluOr;
				fnXor: e.aluOp = aluXor;
				fnNor: e.aluOp = aluNor;
				fnSlt: e.aluOp = aluSlt;
				fnSltu: e.aluOp = aluSltu;
				fnSll, fnSllv: e.aluOp = aluSll;
				fnSrl, fnSrlv: e.aluOp = aluSrl;
				fnSra, fnSrav: e.aluOp = aluSra;
				fnMovz, fnMovn: e.aluOp = aluMove;
				fnJr: begin
					e.regWr = 1'b0;
					e.isBranch = 1'b1;
					e.npcOp = npcJumpReg;
				end
				fnJalr: begin
					e.isBranch = 1'b1;
					e.npcOp = npcJumpReg;
					e.wbSel = wbLink;
				end
				fnMfhi, fnMflo: begin
					e.wbSel = wbHilo;
					e.hiloRdHi = (fn == fnMfhi);
				end
				fnMthi, fnMtlo: begin
					e.regWr = 1'b0;
					e.hiloWr = 1'b1;
					e.hiloWrSel = (fn == fnMthi) ? hiloSelHi : hiloSelLo;
				end
				fnMult, fnMultu, fnDiv, fnDivu: begin
					e.regWr = 1'b0;
					e.hiloWr = 1'b1;
					e.hiloWrSel = hiloSelMd;
					e.mdStart = 1'b1;
					e.wbSel = wbHilo;
				end
				fnSyscall: begin
					e.regWr = 1'b0;
					sys = 1'b1;
				end
				fnBreak: begin
					e.regWr = 1'b0;
					brk = 1'b1;
				end
				fnSync: e.regWr = 1'b0;
				default: begin
					e.regWr = 1'b0;
					known = 1'b0;
				end
			endcase
			e.aluShamtSrc = (fn == fnSll) || (fn == fnSrl) || (fn == fnSra);
			case (fn)
				fnMult: e.mdOp = mdMult;
				fnDiv: e.mdOp = mdDiv;
				fnDivu: e.mdOp = mdDivu;
				default: e.mdOp = mdMultu;
			endcase
			if (fn == fnMovz)
				e.movEnable = rtZero;
			if (fn == fnMovn)
				e.movEnable = !rtZero;
		end
		opAddi: e.aluOp = aluAdd;
		opAddiu: e.aluOp = aluAddu;
		opSlti: e.aluOp = aluSlt;
		opSltiu: e.aluOp = aluSltu;
		opAndi: e.aluOp = aluAnd;
		opOri: e.aluOp = aluOr;
		opXori: e.aluOp = aluXor;
		opLui: e.extOp = extUpper;
		opLb, opLh, opLwl, opLw, opLbu, opLhu, opLwr: memLoad = 1'b1;
		opSb, opSh, opSwl, opSw, opSwr: memStore = 1'b1;
		opBeq: begin
			cond = 1'b1;
			taken = eq;
		end
		opBne: begin
			cond = 1'b1;
			taken = !eq;
		end
		opBlez: begin
			cond = 1'b1;
			taken = (sign != 2'b01);
		end
		opBgtz: begin
			cond = 1'b1;
			taken = (sign == 2'b01);
		end
		opRegimm: begin
			// rt[0] picks GEZ over LTZ, rt[4] adds the link
			e.regDstSel = dstR31;
			e.wbSel = wbLink;
			known = (rt[3:1] == 3'b000);
			cond = known;
			e.regWr = known && rt[4];
			taken = rt[0] ? (sign != 2'b10) : (sign == 2'b10);
		end
		opJ, opJal: begin
			e.isBranch = 1'b1;
			e.npcOp = npcJump;
			if (op == opJal) begin
				e.regWr = 1'b1;
				e.regDstSel = dstR31;
				e.wbSel = wbLink;
			end
		end
		opCop0: begin
			// ERET by funct, MTC0 and MFC0 by rs
			e.eretFlush = (fn == fnEret);
			e.cp0Wr = (iw.rFmt.rs == rsMtc0);
			e.cp0Rd = (iw.rFmt.rs == rsMfc0);
			if (iw.rFmt.rs == rsMfc0) begin
				e.regWr = 1'b1;
				e.wbSel = wbCp0;
			end
		end
		default: known = 1'b0;
	endcase

	// immediate arithmetic and logic write rt
	if (op >= opAddi && op <= opLui)
		e.regWr = 1'b1;
	if (op >= opAddi && op <= opSltiu)
		e.extOp = extSign;
	if (op == opLui)
		e.wbSel = wbImm;

	// loads and stores compute base plus signed offset
	if (memLoad || memStore) begin
		e.aluOp = aluAdd;
		e.extOp = extSign;
	end
	if (memLoad) begin
		e.regWr = 1'b1;
		e.dmRd = 1'b1;
		e.wbSel = wbMem;
	end
	e.dmWr = memStore;
	case (op)
		opSb: e.dmSel = dmSb;
		opSh: e.dmSel = dmSh;
		opSw: e.dmSel = dmSw;
		opSwl: e.dmSel = dmSwl;
		opSwr: e.dmSel = dmSwr;
		opLbu: e.dmSel = dmLbu;
		opLb: e.dmSel = dmLb;
		opLhu: e.dmSel = dmLhu;
		opLh: e.dmSel = dmLh;
		opLwl: e.dmSel = dmLwl;
		opLwr: e.dmSel = dmLwr;
		default: e.dmSel = dmLw;
	endcase

	if (cond) begin
		e.isBranch = 1'b1;
		e.npcOp = taken ? npcBranch : npcSeq;
	end

	// fetch exception first, then RI, break and syscall
	if (fExc) begin
		e.idException = 1'b1;
		e.idExcCode = fCode;
	end else if (!known && !resetWin && !flush) begin
		e.idException = 1'b1;
		e.idExcCode = excRi;
	end else if (brk) begin
		e.idException = 1'b1;
		e.idExcCode = excBp;
	end else if (sys) begin
		e.idException = 1'b1;
		e.idExcCode = excSys;
	end
	return e;
endfunction

`endif

//--- bench/decodeCtrlTb.sv
`timescale 1ns/1ns

module decodeCtrlTb;
	import ctrlPkg::*;

	`include "ctrlRefModel.svh"

	localparam int periodNs = 20;
	localparam int resetCycles = 5;
	localparam int nAlu = 200;
	localparam int nMem = 120;
	localparam int nBr = 200;
	localparam int nHilo = 150;
	localparam int nCop0 = 40;
	localparam int nExc = 120;
	localparam int numVec = 1 + nAlu + nMem + nBr + nHilo + nCop0 + nExc + 4;

	logic clk = 1'b0;
	logic rst;
	instrWord_u instr;
	logic cmpEq;
	logic [1:0] cmpSign;
	logic cmpRtZero;
	logic fetchExc;
	logic [excW-1:0] fetchExcCode;
	logic ifFlush;

	logic regWr;
	logic [regDstW-1:0] regDstSel;
	logic [wbSelW-1:0] wbSel;
	logic [aluOpW-1:0] aluOp;
	logic aluShamtSrc;
	logic [extW-1:0] extOp;
	logic dmWr;
	logic dmRd;
	logic [dmSelW-1:0] dmSel;
	logic hiloWr;
	logic [hiloSelW-1:0] hiloWrSel;
	logic hiloRdHi;
	logic mdStart;
	logic [mdOpW-1:0] mdOp;
	logic aluSrcImm;
	logic isBranch;
	logic eretFlush;
	logic cp0Wr;
	logic cp0Rd;
	logic [npcW-1:0] npcOp;
	logic movEnable;
	logic idException;
	logic [excW-1:0] idExcCode;

	expectOut_t expd;
	logic refPostReset;
	int errCount = 0;
	int rndSeed;
	int junk;
	int i;
	int kind;
	instrWord_u stim;

	logic [functW-1:0] aluFns [16] = '{fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor,
		fnNor, fnSlt, fnSltu, fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav};
	logic [opW-1:0] immOps [8] = '{opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri,
		opXori, opLui};
	logic [opW-1:0] memOps [12] = '{opLb, opLh, opLwl, opLw, opLbu, opLhu, opLwr, opSb,
		opSh, opSwl, opSw, opSwr};
	logic [opW-1:0] ctlOps [6] = '{opBeq, opBne, opBlez, opBgtz, opJ, opJal};
	logic [regW-1:0] regimmRts [4] = '{rtBltz, rtBgez, rtBltzal, rtBgezal};
	logic [functW-1:0] hiloFns [10] = '{fnMfhi, fnMthi, fnMflo, fnMtlo, fnMult, fnMultu,
		fnDiv, fnDivu, fnMovz, fnMovn};
	// the last entry is the CO form used by ERET
	logic [regW-1:0] cop0Rss [3] = '{rsMfc0, rsMtc0, 5'b10000};

	decodeCtrl dut0 (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.cmpEq(cmpEq),
		.cmpSign(cmpSign),
		.cmpRtZero(cmpRtZero),
		.fetchExc(fetchExc),
		.fetchExcCode(fetchExcCode),
		.ifFlush(ifFlush),
		.regWr(regWr),
		.regDstSel(regDstSel),
		.wbSel(wbSel),
		.aluOp(aluOp),
		.aluShamtSrc(aluShamtSrc),
		.extOp(extOp),
		.dmWr(dmWr),
		.dmRd(dmRd),
		.dmSel(dmSel),
		.hiloWr(hiloWr),
		.hiloWrSel(hiloWrSel),
		.hiloRdHi(hiloRdHi),
		.mdStart(mdStart),
		.mdOp(mdOp),
		.aluSrcImm(aluSrcImm),
		.isBranch(isBranch),
		.eretFlush(eretFlush),
		.cp0Wr(cp0Wr),
		.cp0Rd(cp0Rd),
		.npcOp(npcOp),
		.movEnable(movEnable),
		.idException(idException),
		.idExcCode(idExcCode)
	);

	always #(periodNs / 2) clk = ~clk;

	// RI is masked through reset and one cycle past release
	always @(posedge clk)
		refPostReset <= !rst;

	task automatic haltOnError();
		errCount++;
		$display("Simulation failed");
		$fatal(1, "stopped at the first mismatch");
	endtask

	task automatic compareSelect(input string name, input logic [aluOpW-1:0] got,
		input logic [aluOpW-1:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
			haltOnError();
		end
	endtask

	task automatic verifyFlow(input logic [npcW-1:0] gotNpc, input logic [npcW-1:0] expNpc,
		input logic gotMov, input logic expMov);
		if (gotNpc !== expNpc) begin
			$display("** Error at %0t ns: npcOp = %0d, expected %0d", $time, gotNpc, expNpc);
			haltOnError();
		end
		if (gotMov !== expMov) begin
			$display("** Error at %0t ns: movEnable = %0b, expected %0b", $time, gotMov, expMov);
			haltOnError();
		end
	endtask

	task automatic matchException(input logic gotExc, input logic expExc,
		input logic [excW-1:0] gotCode, input logic [excW-1:0] expCode);
		if (gotExc !== expExc) begin
			$display("** Error at %0t ns: idException = %0b, expected %0b", $time, gotExc, expExc);
			haltOnError();
		end
		if (gotCode !== expCode) begin
			$display("** Error at %0t ns: idExcCode = %0d, expected %0d", $time, gotCode, expCode);
			haltOnError();
		end
	endtask

	// comparator flags are random on every vector
	task automatic applyVector(input instrWord_u iw, input logic fExc,
		input logic [excW-1:0] fCode, input logic flush);
		@(posedge clk);
		#2;
		instr = iw;
		cmpEq = $urandom % 2;
		cmpSign = $urandom % 3;
		cmpRtZero = $urandom % 2;
		fetchExc = fExc;
		fetchExcCode = fCode;
		ifFlush = flush;
	endtask

	function automatic logic [opW-1:0] pickUnusedOp();
		logic [opW-1:0] op;
		int r;
		r = $urandom % 35;
		// gaps in the opcode map: 17-31, 39, 44, 45, 47-63
		if (r < 15)
			op = 17 + r;
		else if (r == 15)
			op = 39;
		else if (r < 18)
			op = 28 + r;
		else
			op = 29 + r;
		return op;
	endfunction

	always @(negedge clk) begin
		expd = predictOutputs(instr, cmpEq, cmpSign, cmpRtZero, fetchExc, fetchExcCode,
			ifFlush, refPostReset);
		compareSelect("regWr", regWr, expd.regWr);
		compareSelect("regDstSel", regDstSel, expd.regDstSel);
		compareSelect("wbSel", wbSel, expd.wbSel);
		compareSelect("aluOp", aluOp, expd.aluOp);
		compareSelect("aluShamtSrc", aluShamtSrc, expd.aluShamtSrc);
		compareSelect("extOp", extOp, expd.extOp);
		compareSelect("aluSrcImm", aluSrcImm, expd.aluSrcImm);
		compareSelect("dmWr", dmWr, expd.dmWr);
		compareSelect("dmRd", dmRd, expd.dmRd);
		compareSelect("dmSel", dmSel, expd.dmSel);
		compareSelect("hiloWr", hiloWr, expd.hiloWr);
		compareSelect("hiloWrSel", hiloWrSel, expd.hiloWrSel);
		compareSelect("hiloRdHi", hiloRdHi, expd.hiloRdHi);
		compareSelect("mdStart", mdStart, expd.mdStart);
		compareSelect("mdOp", mdOp, expd.mdOp);
		compareSelect("isBranch", isBranch, expd.isBranch);
		compareSelect("eretFlush", eretFlush, expd.eretFlush);
		compareSelect("cp0Wr", cp0Wr, expd.cp0Wr);
		compareSelect("cp0Rd", cp0Rd, expd.cp0Rd);
		verifyFlow(npcOp, expd.npcOp, movEnable, expd.movEnable);
		matchException(idException, expd.idException, idExcCode, expd.idExcCode);
	end

	initial begin
		#((numVec + resetCycles + 20) * periodNs);
		$display("Timeout: the vectors did not finish in the expected time");
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		rndSeed = 32'h54d4;
		junk = $urandom(rndSeed);
		rst = 1'b0;
		instr = '0;
		cmpEq = 1'b0;
		cmpSign = 2'b00;
		cmpRtZero = 1'b0;
		fetchExc = 1'b0;
		fetchExcCode = '0;
		ifFlush = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#2;
		// unused opcode right at release, no RI yet
		rst = 1'b1;
		stim = $urandom;
		stim.iFmt.op = pickUnusedOp();
		instr = stim;

		// R-type and immediate ALU ops
		for (i = 0; i < nAlu; i++) begin
			stim = $urandom;
			if ($urandom % 2) begin
				stim.rFmt.op = opSpecial;
				stim.rFmt.funct = aluFns[$urandom % 16];
			end else begin
				stim.iFmt.op = immOps[$urandom % 8];
			end
			applyVector(stim, 1'b0, '0, 1'b0);
		end

		for (i = 0; i < nMem; i++) begin
			stim = $urandom;
			stim.iFmt.op = memOps[$urandom % 12];
			applyVector(stim, 1'b0, '0, 1'b0);
		end

		// branches, jumps and register jumps
		for (i = 0; i < nBr; i++) begin
			stim = $urandom;
			kind = $urandom % 9;
			if (kind < 6) begin
				stim.iFmt.op = ctlOps[kind];
			end else if (kind == 6) begin
				stim.iFmt.op = opRegimm;
				stim.iFmt.rt = regimmRts[$urandom % 4];
			end else begin
				stim.rFmt.op = opSpecial;
				stim.rFmt.funct = (kind == 7) ? fnJr : fnJalr;
			end
			applyVector(stim, 1'b0, '0, 1'b0);
		end

		for (i = 0; i < nHilo; i++) begin
			stim = $urandom;
			stim.rFmt.op = opSpecial;
			stim.rFmt.funct = hiloFns[$urandom % 10];
			applyVector(stim, 1'b0, '0, 1'b0);
		end

		// MFC0, MTC0 and ERET
		for (i = 0; i < nCop0; i++) begin
			stim = $urandom;
			stim.rFmt.op = opCop0;
			stim.rFmt.rs = cop0Rss[$urandom % 3];
			if ($urandom % 2)
				stim.rFmt.funct = fnEret;
			applyVector(stim, 1'b0, '0, 1'b0);
		end

		// fixed exception cases, then a random mix
		stim = $urandom;
		stim.iFmt.op = pickUnusedOp();
		applyVector(stim, 1'b0, '0, 1'b0);
		applyVector(stim, 1'b0, '0, 1'b1);
		applyVector(stim, 1'b1, 5'd4, 1'b0);
		stim.rFmt.op = opSpecial;
		stim.rFmt.funct = fnBreak;
		applyVector(stim, 1'b1, 5'd12, 1'b0);
		for (i = 0; i < nExc; i++) begin
			stim = $urandom;
			kind = $urandom % 3;
			if (kind == 0) begin
				stim.iFmt.op = pickUnusedOp();
			end else begin
				stim.rFmt.op = opSpecial;
				stim.rFmt.funct = (kind == 1) ? fnBreak : fnSyscall;
			end
			applyVector(stim, ($urandom % 4) == 0, $urandom, ($urandom % 4) == 0);
		end

		@(negedge clk);
		#1;
		if (errCount == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- decodeCtrl.f
+incdir+include
design/ctrlPkg.sv
design/instrDecoder.sv
design/condResolver.sv
design/excDetect.sv
design/decodeCtrl.sv
bench/decodeCtrlTb.sv
